// ==== design/icache_cfg.svh ====
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// address and line geometry
`define ICACHE_ADDR_W      32
`define ICACHE_WAYS        4
`define ICACHE_LINE_BYTES  64
`define ICACHE_SETS        16

// memory side, one line arrives as eight 64-bit beats
`define ICACHE_BEAT_W      64
`define ICACHE_BEATS       8

// a cpu write here clears every valid bit
`define ICACHE_CTRL_ADDR   32'h0000_FFFC

// deep enough for one whole line
`define ICACHE_FIFO_DEPTH  8

`endif

// ==== design/icache_pkg.sv ====
`default_nettype none

`include "icache_cfg.svh"

package icache_pkg;

    localparam int unsigned OFFSET_W   = $clog2(`ICACHE_LINE_BYTES);
    localparam int unsigned INDEX_W    = $clog2(`ICACHE_SETS);
    localparam int unsigned TAG_W      = `ICACHE_ADDR_W - INDEX_W - OFFSET_W;
    localparam int unsigned BEAT_IDX_W = $clog2(`ICACHE_BEATS);
    localparam int unsigned WAY_W      = $clog2(`ICACHE_WAYS);
    localparam int unsigned WORD_W     = 32;

    // address field positions: tag 31..10, index 9..6, beat 5..3, word 2
    localparam int unsigned WORD_BIT   = 2;
    localparam int unsigned BEAT_LSB   = $clog2(`ICACHE_BEAT_W / 8);
    localparam int unsigned INDEX_LSB  = OFFSET_W;
    localparam int unsigned TAG_LSB    = INDEX_LSB + INDEX_W;

    typedef logic [`ICACHE_ADDR_W-1:0] addr_t;
    typedef logic [TAG_W-1:0]          tag_t;
    typedef logic [INDEX_W-1:0]        index_t;
    typedef logic [BEAT_IDX_W-1:0]     beat_idx_t;
    typedef logic [WAY_W-1:0]          way_t;
    typedef logic [`ICACHE_WAYS-1:0]   way_vec_t;
    typedef logic [`ICACHE_BEAT_W-1:0] beat_t;
    typedef logic [WORD_W-1:0]         word_t;

endpackage

`default_nettype wire

// ==== design/refill_fifo.sv ====
`default_nettype none

module refill_fifo #(
    parameter type         payload_t = logic [63:0],
    parameter int unsigned DEPTH     = 8
) (
    input  wire logic     clk_i,
    input  wire logic     rst_i,
    input  wire logic     push_i,
    input  wire payload_t data_i,
    input  wire logic     pop_i,
    output payload_t      data_o,
    output logic          empty_o
);

    localparam int unsigned PTR_W = $clog2(DEPTH);
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    payload_t   mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_pop;

    assign empty_o = (count_q == '0);
    assign do_pop  = pop_i && !empty_o;

    // --------------------
    // pointers and count
    // --------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({push_i, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // registered output, valid the cycle after a pop
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem[wr_ptr_q] <= data_i;
        end
        if (do_pop) begin
            data_o <= mem[rd_ptr_q];
        end
    end

endmodule

`default_nettype wire

// ==== design/tag_store.sv ====
`default_nettype none

`include "icache_cfg.svh"

module tag_store import icache_pkg::*; (
    input  wire logic   clk_i,
    input  wire logic   rst_i,
    input  wire index_t lookup_index_i,
    input  wire tag_t   lookup_tag_i,
    input  wire logic   alloc_i,
    input  wire way_t   alloc_way_i,
    input  wire logic   inval_i,
    input  wire index_t inval_index_i,
    output way_vec_t    hit_vec_o
);

    tag_t     tag_mem  [`ICACHE_WAYS][`ICACHE_SETS];
    tag_t     tag_rd_q [`ICACHE_WAYS];
    way_vec_t valid_q  [`ICACHE_SETS];
    way_vec_t valid_rd_q;

    // --------------------
    // tag arrays
    // --------------------
    always_ff @(posedge clk_i) begin
        if (alloc_i) begin
            tag_mem[alloc_way_i][lookup_index_i] <= lookup_tag_i;
        end
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            tag_rd_q[w] <= tag_mem[w][lookup_index_i];
        end
    end

    // --------------------
    // valid bits
    // --------------------
    // one vector per set, so a whole set clears in one cycle
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                valid_q[s] <= '0;
            end
            valid_rd_q <= '0;
        end else begin
            if (inval_i) begin
                valid_q[inval_index_i] <= '0;
            end else if (alloc_i) begin
                valid_q[lookup_index_i][alloc_way_i] <= 1'b1;
            end
            valid_rd_q <= valid_q[lookup_index_i];
        end
    end

    // compare against the tag of the held address
    always_comb begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            hit_vec_o[w] = valid_rd_q[w] && (tag_rd_q[w] == lookup_tag_i);
        end
    end

endmodule

`default_nettype wire

// ==== design/data_store.sv ====
`default_nettype none

`include "icache_cfg.svh"

module data_store import icache_pkg::*; (
    input  wire logic      clk_i,
    input  wire logic      en_i,
    input  wire way_vec_t  we_i,
    input  wire index_t    index_i,
    input  wire beat_idx_t row_i,
    input  wire beat_t     wdata_i,
    input  wire way_vec_t  hit_vec_i,
    input  wire logic      word_sel_i,
    output word_t          rdata_o
);

    localparam int unsigned ROWS = `ICACHE_SETS * `ICACHE_BEATS;

    beat_t mem  [`ICACHE_WAYS][ROWS];
    beat_t rd_q [`ICACHE_WAYS];
    beat_t sel_row;

    logic [INDEX_W+BEAT_IDX_W-1:0] row_addr;

    assign row_addr = {index_i, row_i};

    // all ways are read together, the hit picks one afterwards
    always_ff @(posedge clk_i) begin
        if (en_i) begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                if (we_i[w]) begin
                    mem[w][row_addr] <= wdata_i;
                end
                rd_q[w] <= mem[w][row_addr];
            end
        end
    end

    // one-hot select, then the 32-bit half
    always_comb begin
        sel_row = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (hit_vec_i[w]) begin
                sel_row = sel_row | rd_q[w];
            end
        end
        rdata_o = word_sel_i ? sel_row[WORD_W +: WORD_W] : sel_row[0 +: WORD_W];
    end

endmodule

`default_nettype wire

// ==== design/plru_tree.sv ====
`default_nettype none

`include "icache_cfg.svh"

module plru_tree import icache_pkg::*; (
    input  wire logic     clk_i,
    input  wire logic     rst_i,
    input  wire index_t   index_i,
    input  wire logic     update_i,
    input  wire way_vec_t hit_vec_i,
    output way_t          victim_o
);

    // bit 0 picks the half, bit 1 covers ways 0/1, bit 2 covers ways 2/3
    logic [2:0] tree_q [`ICACHE_SETS];
    logic [2:0] tree;
    way_t       hit_way;

    assign tree     = tree_q[index_i];
    assign victim_o = tree[0] ? {1'b1, tree[2]} : {1'b0, tree[1]};

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (hit_vec_i[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                tree_q[s] <= '0;
            end
        end else if (update_i) begin
            // point the path away from the way just used
            if (!hit_way[1]) begin
                tree_q[index_i][0] <= 1'b1;
                tree_q[index_i][1] <= ~hit_way[0];
            end else begin
                tree_q[index_i][0] <= 1'b0;
                tree_q[index_i][2] <= ~hit_way[0];
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/icache_ctrl.sv ====
`default_nettype none

`include "icache_cfg.svh"

module icache_ctrl import icache_pkg::*; (
    input  wire logic     clk_i,
    input  wire logic     rst_i,
    input  wire logic     cpu_rd_i,
    input  wire logic     cpu_wr_i,
    input  wire addr_t    cpu_addr_i,
    input  wire way_vec_t hit_vec_i,
    input  wire way_t     victim_i,
    input  wire logic     fifo_empty_i,
    input  wire beat_t    fifo_data_i,
    output logic          cpu_ready_o,
    output logic          cpu_rsp_valid_o,
    output logic          mem_req_valid_o,
    output addr_t         mem_req_addr_o,
    output index_t        lookup_index_o,
    output tag_t          lookup_tag_o,
    output logic          alloc_o,
    output way_t          alloc_way_o,
    output logic          inval_o,
    output index_t        inval_index_o,
    output logic          plru_update_o,
    output logic          fifo_pop_o,
    output logic          data_en_o,
    output way_vec_t      data_we_o,
    output beat_idx_t     data_row_o,
    output beat_t         data_wdata_o,
    output logic          word_sel_o
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_COMPARE,
        ST_MEM_WAIT,
        ST_FILL,
        ST_INVAL
    } state_e;

    state_e  state_q, state_d;
    addr_t   addr_q;
    way_t    victim_q;
    index_t  inval_cnt_q;
    logic    pop_q;
    logic    hit;
    logic    accept;
    logic    miss;
    logic    fill_done;

    // one extra bit so the counters can reach a full line
    logic [BEAT_IDX_W:0] pop_cnt_q;
    logic [BEAT_IDX_W:0] wr_cnt_q;

    assign accept    = (state_q == ST_IDLE) && (cpu_rd_i || cpu_wr_i);
    assign hit       = |hit_vec_i;
    assign miss      = (state_q == ST_COMPARE) && !hit;
    assign fill_done = wr_cnt_q[BEAT_IDX_W];

    // --------------------
    // cpu and memory side
    // --------------------
    assign cpu_ready_o     = (state_q == ST_IDLE);
    assign cpu_rsp_valid_o = (state_q == ST_COMPARE) && hit;
    assign mem_req_valid_o = miss;
    assign mem_req_addr_o  = {addr_q[`ICACHE_ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

    // idle looks up the incoming address, every other state the held one
    assign lookup_index_o = (state_q == ST_IDLE) ? cpu_addr_i[INDEX_LSB +: INDEX_W]
                                                 : addr_q[INDEX_LSB +: INDEX_W];
    assign lookup_tag_o   = addr_q[TAG_LSB +: TAG_W];

    // allocate the victim in the same cycle as the memory request
    assign alloc_o       = miss;
    assign alloc_way_o   = victim_i;
    assign plru_update_o = cpu_rsp_valid_o;

    assign inval_o       = (state_q == ST_INVAL);
    assign inval_index_o = inval_cnt_q;

    // --------------------
    // line fill
    // --------------------
    // fifo data shows up one cycle after the pop, so writes trail pops by one
    assign fifo_pop_o   = (state_q == ST_FILL) && !fifo_empty_i && !pop_cnt_q[BEAT_IDX_W];
    assign data_we_o    = pop_q ? (way_vec_t'(1) << victim_q) : '0;
    assign data_wdata_o = fifo_data_i;

    // read on accept, write each beat, and re-read once the line is complete
    assign data_en_o = (accept && cpu_rd_i) || pop_q || ((state_q == ST_FILL) && fill_done);

    always_comb begin
        if (pop_q) begin
            data_row_o = wr_cnt_q[BEAT_IDX_W-1:0];
        end else if (state_q == ST_IDLE) begin
            data_row_o = cpu_addr_i[BEAT_LSB +: BEAT_IDX_W];
        end else begin
            data_row_o = addr_q[BEAT_LSB +: BEAT_IDX_W];
        end
    end

    assign word_sel_o = addr_q[WORD_BIT];

    // --------------------
    // state machine
    // --------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (cpu_rd_i) begin
                    state_d = ST_COMPARE;
                end else if (cpu_wr_i && (cpu_addr_i == `ICACHE_CTRL_ADDR)) begin
                    state_d = ST_INVAL;
                end
            end
            ST_COMPARE: begin
                state_d = hit ? ST_IDLE : ST_MEM_WAIT;
            end
            ST_MEM_WAIT: begin
                if (!fifo_empty_i) begin
                    state_d = ST_FILL;
                end
            end
            ST_FILL: begin
                if (fill_done) begin
                    state_d = ST_COMPARE;
                end
            end
            ST_INVAL: begin
                if (inval_cnt_q == index_t'(`ICACHE_SETS - 1)) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q     <= ST_IDLE;
            victim_q    <= '0;
            inval_cnt_q <= '0;
            pop_cnt_q   <= '0;
            wr_cnt_q    <= '0;
            pop_q       <= 1'b0;
        end else begin
            state_q <= state_d;
            pop_q   <= fifo_pop_o;
            if (miss) begin
                victim_q  <= victim_i;
                pop_cnt_q <= '0;
                wr_cnt_q  <= '0;
            end else begin
                if (fifo_pop_o) begin
                    pop_cnt_q <= pop_cnt_q + 1'b1;
                end
                if (pop_q) begin
                    wr_cnt_q <= wr_cnt_q + 1'b1;
                end
            end
            // wraps back to zero after the last set
            if (state_q == ST_INVAL) begin
                inval_cnt_q <= inval_cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            addr_q <= cpu_addr_i;
        end
    end

endmodule

`default_nettype wire

// ==== design/icache_top.sv ====
`default_nettype none

`include "icache_cfg.svh"

module icache_top import icache_pkg::*; (
    input  wire logic  clk_i,
    input  wire logic  rst_i,

    // cpu side
    input  wire logic  cpu_rd_i,
    input  wire logic  cpu_wr_i,
    input  wire addr_t cpu_addr_i,
    output logic       cpu_ready_o,
    output logic       cpu_rsp_valid_o,
    output word_t      cpu_rsp_data_o,

    // memory side
    output logic       mem_req_valid_o,
    output addr_t      mem_req_addr_o,
    input  wire logic  mem_beat_valid_i,
    input  wire beat_t mem_beat_data_i
);

    way_vec_t  hit_vec;
    way_t      victim;
    index_t    lookup_index;
    tag_t      lookup_tag;
    logic      alloc;
    way_t      alloc_way;
    logic      inval;
    index_t    inval_index;
    logic      plru_update;
    logic      fifo_pop;
    logic      fifo_empty;
    beat_t     fifo_data;
    logic      data_en;
    way_vec_t  data_we;
    beat_idx_t data_row;
    beat_t     data_wdata;
    logic      word_sel;

    icache_ctrl u_ctrl (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .cpu_rd_i        (cpu_rd_i),
        .cpu_wr_i        (cpu_wr_i),
        .cpu_addr_i      (cpu_addr_i),
        .hit_vec_i       (hit_vec),
        .victim_i        (victim),
        .fifo_empty_i    (fifo_empty),
        .fifo_data_i     (fifo_data),
        .cpu_ready_o     (cpu_ready_o),
        .cpu_rsp_valid_o (cpu_rsp_valid_o),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_addr_o  (mem_req_addr_o),
        .lookup_index_o  (lookup_index),
        .lookup_tag_o    (lookup_tag),
        .alloc_o         (alloc),
        .alloc_way_o     (alloc_way),
        .inval_o         (inval),
        .inval_index_o   (inval_index),
        .plru_update_o   (plru_update),
        .fifo_pop_o      (fifo_pop),
        .data_en_o       (data_en),
        .data_we_o       (data_we),
        .data_row_o      (data_row),
        .data_wdata_o    (data_wdata),
        .word_sel_o      (word_sel)
    );

    tag_store u_tag_store (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .lookup_index_i (lookup_index),
        .lookup_tag_i   (lookup_tag),
        .alloc_i        (alloc),
        .alloc_way_i    (alloc_way),
        .inval_i        (inval),
        .inval_index_i  (inval_index),
        .hit_vec_o      (hit_vec)
    );

    // the data arrays share the set index of the tag lookup
    data_store u_data_store (
        .clk_i      (clk_i),
        .en_i       (data_en),
        .we_i       (data_we),
        .index_i    (lookup_index),
        .row_i      (data_row),
        .wdata_i    (data_wdata),
        .hit_vec_i  (hit_vec),
        .word_sel_i (word_sel),
        .rdata_o    (cpu_rsp_data_o)
    );

    plru_tree u_plru (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .index_i   (lookup_index),
        .update_i  (plru_update),
        .hit_vec_i (hit_vec),
        .victim_o  (victim)
    );

    refill_fifo #(
        .payload_t (beat_t),
        .DEPTH     (`ICACHE_FIFO_DEPTH)
    ) u_refill_fifo (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .push_i  (mem_beat_valid_i),
        .data_i  (mem_beat_data_i),
        .pop_i   (fifo_pop),
        .data_o  (fifo_data),
        .empty_o (fifo_empty)
    );

endmodule

`default_nettype wire

// ==== sim/icache_tb_tasks.svh ====
`ifndef ICACHE_TB_TASKS_SVH
`define ICACHE_TB_TASKS_SVH

// reference model, one 3-bit tree per set
tag_t       ref_tag   [`ICACHE_SETS][`ICACHE_WAYS];
logic       ref_valid [`ICACHE_SETS][`ICACHE_WAYS];
logic [2:0] ref_tree  [`ICACHE_SETS];

// --------------------
// random numbers
// --------------------
// x^17 + x^14 + 1
function automatic logic [16:0] lfsr_next(input logic [16:0] s);
    return {s[15:0], s[16] ^ s[13]};
endfunction

task automatic draw_bits(inout logic [16:0] state, input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
        state = lfsr_next(state);
        value = {value[30:0], state[0]};
    end
endtask

// --------------------
// checks
// --------------------
task automatic compare_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
        errors++;
        $display("** Error: %s = %h, expected %h", name, got, exp);
    end
endtask

task automatic require(input logic cond, input string what);
    checks++;
    assert (cond) else begin
        errors++;
        $display("error: %s", what);
    end
endtask

// --------------------
// reference model
// --------------------
task automatic forget_all_lines();
    for (int s = 0; s < `ICACHE_SETS; s++) begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            ref_valid[s][w] = 1'b0;
        end
    end
endtask

task automatic model_reset();
    forget_all_lines();
    for (int s = 0; s < `ICACHE_SETS; s++) begin
        ref_tree[s] = 3'b000;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            ref_tag[s][w] = '0;
        end
    end
endtask

// root bit picks the half, then bit 1 or bit 2 picks the way inside it
function automatic way_t tree_victim(input logic [2:0] t);
    return t[0] ? {1'b1, t[2]} : {1'b0, t[1]};
endfunction

function automatic logic [2:0] tree_touch(input logic [2:0] t, input way_t w);
    logic [2:0] n;
    n    = t;
    n[0] = ~w[1];
    if (w[1]) begin
        n[2] = ~w[0];
    end else begin
        n[1] = ~w[0];
    end
    return n;
endfunction

task automatic model_access(input addr_t a, output logic hit);
    index_t idx;
    tag_t   tg;
    way_t   way;
    idx = a[9:6];
    tg  = a[31:10];
    hit = 1'b0;
    way = '0;
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
        if (ref_valid[idx][w] && ref_tag[idx][w] == tg) begin
            hit = 1'b1;
            way = way_t'(w);
        end
    end
    if (!hit) begin
        way                 = tree_victim(ref_tree[idx]);
        ref_tag[idx][way]   = tg;
        ref_valid[idx][way] = 1'b1;
    end
    // the refill ends in a hit, so a miss touches its way too
    ref_tree[idx] = tree_touch(ref_tree[idx], way);
endtask

// --------------------
// bus actions
// --------------------
task automatic read_word(input addr_t a);
    logic exp_hit;
    int   reqs_before;
    model_access(a, exp_hit);
    while (cpu_ready_o !== 1'b1) begin
        @(negedge clk_i);
    end
    reqs_before = mem_req_cnt;
    cpu_addr_i  = a;
    cpu_rd_i    = 1'b1;
    @(negedge clk_i);
    cpu_rd_i = 1'b0;
    // one cycle after acceptance: either the response or the line request
    compare_value("cpu_rsp_valid_o", 32'(cpu_rsp_valid_o), 32'(exp_hit));
    compare_value("mem_req_valid_o", 32'(mem_req_valid_o), 32'(!exp_hit));
    if (!exp_hit) begin
        compare_value("mem_req_addr_o", mem_req_addr_o, {a[31:6], 6'b0});
        while (cpu_rsp_valid_o !== 1'b1) begin
            @(negedge clk_i);
        end
    end
    compare_value("cpu_rsp_data_o", cpu_rsp_data_o, a);
    compare_value("cpu_ready_o", 32'(cpu_ready_o), 32'd0);
    @(negedge clk_i);
    compare_value("cpu_ready_o", 32'(cpu_ready_o), 32'd1);
    require(mem_req_cnt - reqs_before == (exp_hit ? 0 : 1),
            $sformatf("read of %h made %0d line requests", a, mem_req_cnt - reqs_before));
endtask

// --------------------
// directed tests
// --------------------
task automatic after_reset_state();
    compare_value("cpu_ready_o", 32'(cpu_ready_o), 32'd1);
    compare_value("cpu_rsp_valid_o", 32'(cpu_rsp_valid_o), 32'd0);
    compare_value("mem_req_valid_o", 32'(mem_req_valid_o), 32'd0);
endtask

task automatic cold_miss();
    read_word(32'h0000_0104);
endtask

task automatic hits_in_line();
    for (int w = 0; w < 16; w += 3) begin
        read_word(32'h0000_0100 + addr_t'(4 * w));
    end
endtask

// five tags in set 9, one more than the ways
task automatic replacement_in_set();
    tag_t fill_tags [5];
    tag_t reread    [5];
    fill_tags = '{22'h010, 22'h011, 22'h012, 22'h013, 22'h014};
    reread    = '{22'h010, 22'h012, 22'h014, 22'h011, 22'h010};
    foreach (fill_tags[i]) begin
        read_word({fill_tags[i], 4'd9, 6'h24});
    end
    foreach (reread[i]) begin
        read_word({reread[i], 4'd9, 6'h08});
    end
endtask

task automatic invalidate_all();
    int low_cycles;
    read_word(32'h0000_0100);
    // a plain write elsewhere is dropped
    cpu_addr_i = 32'h0000_0200;
    cpu_wr_i   = 1'b1;
    @(negedge clk_i);
    cpu_wr_i = 1'b0;
    compare_value("cpu_ready_o", 32'(cpu_ready_o), 32'd1);
    compare_value("cpu_rsp_valid_o", 32'(cpu_rsp_valid_o), 32'd0);
    cpu_addr_i = `ICACHE_CTRL_ADDR;
    cpu_wr_i   = 1'b1;
    @(negedge clk_i);
    cpu_wr_i   = 1'b0;
    low_cycles = 0;
    while (cpu_ready_o !== 1'b1 && low_cycles <= 32) begin
        low_cycles++;
        @(negedge clk_i);
    end
    require(low_cycles == 16,
            $sformatf("cpu_ready_o stayed low for %0d cycles instead of 16", low_cycles));
    forget_all_lines();
    read_word(32'h0000_0100);
endtask

// word addresses inside the lowest 2 KiB
task automatic random_reads();
    logic [31:0] pick;
    for (int n = 0; n < 60; n++) begin
        draw_bits(addr_lfsr, 9, pick);
        read_word({21'd0, pick[8:0], 2'b00});
    end
endtask

`endif

// ==== sim/icache_tb.sv ====
`default_nettype none

`include "icache_cfg.svh"

module icache_tb import icache_pkg::*; ();

    // about 50 line fills of up to 40 cycles each, doubled for the hits and margin
    localparam int FILL_BUDGET = 50;
    localparam int FILL_CYCLES = 40;
    localparam int MAX_CYCLES  = 2 * FILL_BUDGET * FILL_CYCLES;

    logic  clk_i = 1'b0;
    logic  rst_i;
    logic  cpu_rd_i;
    logic  cpu_wr_i;
    addr_t cpu_addr_i;
    logic  cpu_ready_o;
    logic  cpu_rsp_valid_o;
    word_t cpu_rsp_data_o;
    logic  mem_req_valid_o;
    addr_t mem_req_addr_o;
    logic  mem_beat_valid_i;
    beat_t mem_beat_data_i;

    int          checks;
    int          errors;
    int          mem_req_cnt;
    logic        timed_out;
    logic [16:0] addr_lfsr;
    logic [16:0] beat_lfsr;

    icache_top DUT (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .cpu_rd_i         (cpu_rd_i),
        .cpu_wr_i         (cpu_wr_i),
        .cpu_addr_i       (cpu_addr_i),
        .cpu_ready_o      (cpu_ready_o),
        .cpu_rsp_valid_o  (cpu_rsp_valid_o),
        .cpu_rsp_data_o   (cpu_rsp_data_o),
        .mem_req_valid_o  (mem_req_valid_o),
        .mem_req_addr_o   (mem_req_addr_o),
        .mem_beat_valid_i (mem_beat_valid_i),
        .mem_beat_data_i  (mem_beat_data_i)
    );

    always #50 clk_i = ~clk_i;

    `include "icache_tb_tasks.svh"

    task automatic finish_run();
        $display("checks: %0d, errors: %0d, timeout: %0d", checks, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    // --------------------
    // memory model
    // --------------------
    // each beat carries its own row address in the low word and row + 4 in the high word
    initial begin : memory_model
        addr_t       line;
        addr_t       row;
        logic [31:0] gap;
        mem_beat_valid_i = 1'b0;
        mem_beat_data_i  = '0;
        mem_req_cnt      = 0;
        beat_lfsr        = 17'd91653;
        forever begin
            @(negedge clk_i);
            if (mem_req_valid_o === 1'b1) begin
                line = mem_req_addr_o;
                mem_req_cnt++;
                for (int k = 0; k < `ICACHE_BEATS; k++) begin
                    draw_bits(beat_lfsr, 2, gap);
                    repeat (gap) @(negedge clk_i);
                    row              = line + addr_t'(8 * k);
                    mem_beat_valid_i = 1'b1;
                    mem_beat_data_i  = {row + 32'd4, row};
                    @(negedge clk_i);
                    mem_beat_valid_i = 1'b0;
                end
            end
        end
    end

    initial begin : watchdog
        int cycle_cnt;
        cycle_cnt = 0;
        timed_out = 1'b0;
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        $display("the tests did not complete within %0d cycles", MAX_CYCLES);
        timed_out = 1'b1;
        finish_run();
    end

    initial begin
        rst_i      = 1'b1;
        cpu_rd_i   = 1'b0;
        cpu_wr_i   = 1'b0;
        cpu_addr_i = '0;
        checks     = 0;
        errors     = 0;
        addr_lfsr  = 17'd91653;
        model_reset();
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;
        after_reset_state();
        cold_miss();
        hits_in_line();
        replacement_in_set();
        invalidate_all();
        random_reads();
        finish_run();
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+design
+incdir+sim
design/icache_pkg.sv
design/refill_fifo.sv
design/tag_store.sv
design/data_store.sv
design/plru_tree.sv
design/icache_ctrl.sv
design/icache_top.sv
sim/icache_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = icache_tb
FILELIST  = project.f
OBJ_DIR   = obj_dir
PASS_MSG  = sim passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
